/* hdl/shell_pkg.sv */
`default_nettype none

package shell_pkg;

   // bus widths
   localparam int addr_width_lp      = 32;
   // the second general-purpose port drops the top two address bits
   localparam int host_addr_width_lp = 30;
   localparam int data_width_lp      = 32;
   localparam int strb_width_lp      = data_width_lp / 8;

   // accelerator DRAM starts here in its own address space
   localparam logic [addr_width_lp-1:0] accel_dram_base_lp = 32'h8000_0000;
   // 120 MiB of the PS-allocated region is available to the accelerator
   localparam logic [addr_width_lp-1:0] dram_limit_lp      = 32'd125_829_120;

   // host window decode
   localparam int host_sel_bit_lp  = 29;
   localparam int host_low_bits_lp = 28;

   // each profiler region covers 8 MiB of accelerator DRAM
   localparam int prof_regions_lp = 128;
   localparam int prof_top_bit_lp = 29;

   // register word map
   localparam int csr_addr_width_lp = 3;
   localparam logic [csr_addr_width_lp-1:0] csr_ctrl_lp   = 3'd0;
   localparam logic [csr_addr_width_lp-1:0] csr_alloc_lp  = 3'd1;
   localparam logic [csr_addr_width_lp-1:0] csr_base_lp   = 3'd2;
   localparam logic [csr_addr_width_lp-1:0] csr_status_lp = 3'd3;
   // profiler words follow at indices 4 to 7, lowest bits first
   localparam logic [csr_addr_width_lp-1:0] csr_prof0_lp  = 3'd4;

   // request as it arrives from the host port
   typedef struct packed {
      logic [host_addr_width_lp-1:0] addr;
      logic                          we;
      logic [data_width_lp-1:0]      data;
      logic [strb_width_lp-1:0]      strb;
   } host_req_t;

   // request in accelerator or DRAM address space
   typedef struct packed {
      logic [addr_width_lp-1:0] addr;
      logic                     we;
      logic [data_width_lp-1:0] data;
      logic [strb_width_lp-1:0] strb;
   } accel_req_t;

endpackage

`default_nettype wire

/* hdl/req_slice.sv */
`default_nettype none

module req_slice
   #(parameter type payload_t = logic)
   (input  wire logic     clk_i
    , input  wire logic   reset_i

    , input  wire logic   in_valid_i
    , output logic        in_ready_o
    , input  wire payload_t in_data_i

    , output logic        out_valid_o
    , input  wire logic   out_ready_i
    , output payload_t    out_data_o
    );

   logic     valid_r;
   payload_t data_r;

   // accept when empty or when the held item leaves this cycle
   assign in_ready_o = ~valid_r | out_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         valid_r <= 1'b0;
      end
      else if (in_ready_o)
      begin
         valid_r <= in_valid_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (in_valid_i & in_ready_o)
      begin
         data_r <= in_data_i;
      end
   end

   assign out_valid_o = valid_r;
   assign out_data_o  = data_r;

   // a stalled item must stay put until the consumer takes it
   hold_under_stall_a : assert property (@(posedge clk_i) disable iff (reset_i)
      (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)));

endmodule

`default_nettype wire

/* hdl/host_window_map.sv */
`default_nettype none

module host_window_map
   (input  wire logic                   clk_i
    , input  wire logic                 reset_i

    , input  wire logic                 host_valid_i
    , output logic                      host_ready_o
    , input  wire shell_pkg::host_req_t host_req_i

    , output logic                      accel_valid_o
    , input  wire logic                 accel_ready_i
    , output shell_pkg::accel_req_t     accel_req_o
    );

   shell_pkg::accel_req_t xlat_req;

   // host 0x0xxx_xxxx lands in accelerator DRAM at 0x8xxx_xxxx, and host
   // 0x2xxx_xxxx reaches the low local space at 0x0xxx_xxxx
   always_comb
   begin
      xlat_req.addr = {~host_req_i.addr[shell_pkg::host_sel_bit_lp]
                       , 3'b000
                       , host_req_i.addr[shell_pkg::host_low_bits_lp-1:0]};
      xlat_req.we   = host_req_i.we;
      xlat_req.data = host_req_i.data;
      xlat_req.strb = host_req_i.strb;
   end

   req_slice #(.payload_t(shell_pkg::accel_req_t)) slice_i
      (.clk_i        (clk_i)
       , .reset_i    (reset_i)
       , .in_valid_i (host_valid_i)
       , .in_ready_o (host_ready_o)
       , .in_data_i  (xlat_req)
       , .out_valid_o(accel_valid_o)
       , .out_ready_i(accel_ready_i)
       , .out_data_o (accel_req_o)
       );

   // the request presented one cycle after a host transfer carries the window bits
   window_map_a : assert property (@(posedge clk_i) disable iff (reset_i)
      (host_valid_i && host_ready_o) |=>
         (accel_valid_o && accel_req_o.addr[30:28] == 3'b000
          && accel_req_o.addr[27:0] == $past(host_req_i.addr[27:0])));

endmodule

`default_nettype wire

/* hdl/dram_rebase.sv */
`default_nettype none

module dram_rebase
   (input  wire logic                                clk_i
    , input  wire logic                              reset_i
    , input  wire logic                              accel_reset_i
    , input  wire logic [shell_pkg::addr_width_lp-1:0] dram_base_i

    , input  wire logic                              req_valid_i
    , output logic                                   req_ready_o
    , input  wire shell_pkg::accel_req_t             req_i

    , output logic                                   dram_valid_o
    , input  wire logic                              dram_ready_i
    , output shell_pkg::accel_req_t                  dram_req_o

    , output logic                                   overrun_o
    );

   logic [shell_pkg::addr_width_lp-1:0] dram_offset;
   shell_pkg::accel_req_t               rebased_req;
   logic                                in_fire;
   logic                                overrun_r;

   // strip the accelerator DRAM base, then land in the PS-allocated region
   assign dram_offset = req_i.addr ^ shell_pkg::accel_dram_base_lp;

   always_comb
   begin
      rebased_req      = req_i;
      rebased_req.addr = dram_offset + dram_base_i;
   end

   assign in_fire = req_valid_i & req_ready_o;

   req_slice #(.payload_t(shell_pkg::accel_req_t)) slice_i
      (.clk_i        (clk_i)
       , .reset_i    (reset_i)
       , .in_valid_i (req_valid_i)
       , .in_ready_o (req_ready_o)
       , .in_data_i  (rebased_req)
       , .out_valid_o(dram_valid_o)
       , .out_ready_i(dram_ready_i)
       , .out_data_o (dram_req_o)
       );

   // sticky until the accelerator is put back into reset
   always_ff @(posedge clk_i)
   begin
      if (accel_reset_i)
      begin
         overrun_r <= 1'b0;
      end
      else if (in_fire && dram_offset >= shell_pkg::dram_limit_lp)
      begin
         overrun_r <= 1'b1;
      end
   end

   assign overrun_o = overrun_r;

   overrun_sticky_a : assert property (@(posedge clk_i) disable iff (reset_i)
      $fell(overrun_o) |-> $past(accel_reset_i));

endmodule

`default_nettype wire

/* hdl/mem_profiler.sv */
`default_nettype none

module mem_profiler
   (input  wire logic                                  clk_i
    , input  wire logic                                accel_reset_i

    , input  wire logic                                touch_i
    , input  wire logic [shell_pkg::addr_width_lp-1:0] touch_addr_i

    , output logic [shell_pkg::prof_regions_lp-1:0]    bitmap_o
    );

   localparam int idx_width_lp = $clog2(shell_pkg::prof_regions_lp);

   logic [idx_width_lp-1:0] region_idx;

   // the region index sits just below the two top address bits
   assign region_idx = touch_addr_i[shell_pkg::prof_top_bit_lp -: idx_width_lp];

   // bits only ever get set here, so the host sees every region the
   // accelerator has used since it left reset
   always_ff @(posedge clk_i)
   begin
      if (accel_reset_i)
      begin
         bitmap_o <= '0;
      end
      else if (touch_i)
      begin
         bitmap_o[region_idx] <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hdl/shell_csr.sv */
`default_nettype none

module shell_csr
   (input  wire logic                                      clk_i
    , input  wire logic                                    reset_i

    , input  wire logic                                    csr_we_i
    , input  wire logic                                    csr_re_i
    , input  wire logic [shell_pkg::csr_addr_width_lp-1:0] csr_addr_i
    , input  wire logic [shell_pkg::data_width_lp-1:0]     csr_wdata_i
    , output logic [shell_pkg::data_width_lp-1:0]          csr_rdata_o
    , output logic                                         csr_rvalid_o

    , output logic                                         run_o
    , output logic [shell_pkg::addr_width_lp-1:0]          dram_base_o

    , input  wire logic                                    overrun_i
    , input  wire logic [shell_pkg::prof_regions_lp-1:0]   bitmap_i
    );

   localparam int dw_lp = shell_pkg::data_width_lp;

   logic [dw_lp-1:0] ctrl_r;
   logic [dw_lp-1:0] alloc_r;
   logic [dw_lp-1:0] base_r;
   logic [dw_lp-1:0] rdata_r;
   logic             rvalid_r;

   logic [shell_pkg::csr_addr_width_lp-1:0]            prof_sel;
   logic [shell_pkg::prof_regions_lp/dw_lp-1:0][dw_lp-1:0] prof_words;
   logic [dw_lp-1:0]                                   rd_word;

   // only the three host-owned words are writable
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         ctrl_r  <= '0;
         alloc_r <= '0;
         base_r  <= '0;
      end
      else if (csr_we_i)
      begin
         case (csr_addr_i)
            shell_pkg::csr_ctrl_lp:  ctrl_r  <= csr_wdata_i;
            shell_pkg::csr_alloc_lp: alloc_r <= csr_wdata_i;
            shell_pkg::csr_base_lp:  base_r  <= csr_wdata_i;
            default:                 ;
         endcase
      end
   end

   // view the bitmap as four words, bits 0 to 31 in word 0
   assign prof_words = bitmap_i;
   assign prof_sel   = csr_addr_i - shell_pkg::csr_prof0_lp;

   always_comb
   begin
      case (csr_addr_i)
         shell_pkg::csr_ctrl_lp:   rd_word = ctrl_r;
         shell_pkg::csr_alloc_lp:  rd_word = alloc_r;
         shell_pkg::csr_base_lp:   rd_word = base_r;
         shell_pkg::csr_status_lp: rd_word = {{(dw_lp-1){1'b0}}, overrun_i};
         default:                  rd_word = prof_words[prof_sel[1:0]];
      endcase
   end

   // read data comes back on the edge after the strobe
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rvalid_r <= 1'b0;
         rdata_r  <= '0;
      end
      else
      begin
         rvalid_r <= csr_re_i;
         if (csr_re_i)
         begin
            rdata_r <= rd_word;
         end
      end
   end

   assign csr_rdata_o  = rdata_r;
   assign csr_rvalid_o = rvalid_r;

   // the accelerator only runs while bit 0 of the control word is set
   assign run_o       = ctrl_r[0];
   assign dram_base_o = base_r;

endmodule

`default_nettype wire

/* hdl/zynq_accel_shell.sv */
`default_nettype none

module zynq_accel_shell
   (input  wire logic                                      clk_i
    , input  wire logic                                    reset_i

    // register port
    , input  wire logic                                    csr_we_i
    , input  wire logic                                    csr_re_i
    , input  wire logic [shell_pkg::csr_addr_width_lp-1:0] csr_addr_i
    , input  wire logic [shell_pkg::data_width_lp-1:0]     csr_wdata_i
    , output logic [shell_pkg::data_width_lp-1:0]          csr_rdata_o
    , output logic                                         csr_rvalid_o

    // host requests from the second general-purpose port
    , input  wire logic                                    host_valid_i
    , output logic                                         host_ready_o
    , input  wire shell_pkg::host_req_t                    host_req_i

    // host requests translated into accelerator space
    , output logic                                         acc_host_valid_o
    , input  wire logic                                    acc_host_ready_i
    , output shell_pkg::accel_req_t                        acc_host_req_o

    // accelerator DRAM requests
    , input  wire logic                                    acc_dram_valid_i
    , output logic                                         acc_dram_ready_o
    , input  wire shell_pkg::accel_req_t                   acc_dram_req_i

    // rebased requests toward the PS DRAM port
    , output logic                                         dram_valid_o
    , input  wire logic                                    dram_ready_i
    , output shell_pkg::accel_req_t                        dram_req_o

    , output logic                                         accel_reset_o
    );

   logic                                  run;
   logic [shell_pkg::addr_width_lp-1:0]   dram_base;
   logic                                  overrun;
   logic [shell_pkg::prof_regions_lp-1:0] bitmap;
   logic                                  dram_in_fire;

   // the accelerator can be held in reset from software, so a new run
   // starts without reloading the bitstream
   assign accel_reset_o = reset_i | ~run;

   assign dram_in_fire = acc_dram_valid_i & acc_dram_ready_o;

   shell_csr csr_i
      (.clk_i         (clk_i)
       , .reset_i     (reset_i)
       , .csr_we_i    (csr_we_i)
       , .csr_re_i    (csr_re_i)
       , .csr_addr_i  (csr_addr_i)
       , .csr_wdata_i (csr_wdata_i)
       , .csr_rdata_o (csr_rdata_o)
       , .csr_rvalid_o(csr_rvalid_o)
       , .run_o       (run)
       , .dram_base_o (dram_base)
       , .overrun_i   (overrun)
       , .bitmap_i    (bitmap)
       );

   host_window_map host_map_i
      (.clk_i          (clk_i)
       , .reset_i      (reset_i)
       , .host_valid_i (host_valid_i)
       , .host_ready_o (host_ready_o)
       , .host_req_i   (host_req_i)
       , .accel_valid_o(acc_host_valid_o)
       , .accel_ready_i(acc_host_ready_i)
       , .accel_req_o  (acc_host_req_o)
       );

   dram_rebase rebase_i
      (.clk_i          (clk_i)
       , .reset_i      (reset_i)
       , .accel_reset_i(accel_reset_o)
       , .dram_base_i  (dram_base)
       , .req_valid_i  (acc_dram_valid_i)
       , .req_ready_o  (acc_dram_ready_o)
       , .req_i        (acc_dram_req_i)
       , .dram_valid_o (dram_valid_o)
       , .dram_ready_i (dram_ready_i)
       , .dram_req_o   (dram_req_o)
       , .overrun_o    (overrun)
       );

   // profile on the accelerator-side address, before rebasing
   mem_profiler profiler_i
      (.clk_i          (clk_i)
       , .accel_reset_i(accel_reset_o)
       , .touch_i      (dram_in_fire)
       , .touch_addr_i (acc_dram_req_i.addr)
       , .bitmap_o     (bitmap)
       );

endmodule

`default_nettype wire

/* verif/tb_zynq_accel_shell.sv */
`default_nettype none

module tb_zynq_accel_shell;
   timeunit 1ns;
   timeprecision 100ps;

   logic                  clk_i;
   logic                  reset_i;
   logic                  csr_we_i;
   logic                  csr_re_i;
   logic [2:0]            csr_addr_i;
   logic [31:0]           csr_wdata_i;
   logic [31:0]           csr_rdata_o;
   logic                  csr_rvalid_o;
   logic                  host_valid_i;
   logic                  host_ready_o;
   shell_pkg::host_req_t  host_req_i;
   logic                  acc_host_valid_o;
   logic                  acc_host_ready_i;
   shell_pkg::accel_req_t acc_host_req_o;
   logic                  acc_dram_valid_i;
   logic                  acc_dram_ready_o;
   shell_pkg::accel_req_t acc_dram_req_i;
   logic                  dram_valid_o;
   logic                  dram_ready_i;
   shell_pkg::accel_req_t dram_req_o;
   logic                  accel_reset_o;

   integer seed;
   int     cycle_count;
   int     cycle_limit;
   int     stim_cycles;
   int     error_count;
   int     check_count;
   int     test_count;
   int     failed_tests;
   int     test_no;
   int     test_err_base;
   logic   stall;

   // one entry per stimulus line
   logic [7:0]  op_q[$];
   logic [31:0] f1_q[$];
   logic [31:0] f2_q[$];
   logic [31:0] f3_q[$];
   logic [31:0] f4_q[$];

   // expected requests on the two output channels, oldest first
   shell_pkg::accel_req_t host_exp_q[$];
   shell_pkg::accel_req_t dram_exp_q[$];
   shell_pkg::accel_req_t host_hold;
   shell_pkg::accel_req_t dram_hold;
   shell_pkg::accel_req_t host_pop;
   shell_pkg::accel_req_t dram_pop;
   logic                  host_waiting;
   logic                  dram_waiting;

   zynq_accel_shell zynq_accel_shell_i (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   task automatic compare_value(input string name, input logic [127:0] actual,
                                input logic [127:0] expected);
      check_count++;
      if (actual !== expected)
      begin
         $display("FAIL at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
         error_count++;
      end
   endtask

   task automatic load_stimulus();
      int          fd;
      int          n;
      string       line;
      logic [7:0]  op;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      logic [31:0] f4;
      fd = $fopen("verif/shell_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the stimulus file verif/shell_stimulus.txt");
         error_count++;
         return;
      end
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() < 2 || line[0] == "#")
            continue;
         n = $sscanf(line, "%c %h %h %h %h", op, f1, f2, f3, f4);
         if (n != 5)
         begin
            $display("stimulus line could not be parsed: %s", line);
            error_count++;
            continue;
         end
         op_q.push_back(op);
         f1_q.push_back(f1);
         f2_q.push_back(f2);
         f3_q.push_back(f3);
         f4_q.push_back(f4);
         stim_cycles += (op == "S") ? int'(f1) : 1;
      end
      $fclose(fd);
   endtask

   // move to just after the next rising edge, drop strobes, pick new ready levels
   task automatic next_cycle();
      @(posedge clk_i);
      #1;
      csr_we_i         = 1'b0;
      csr_re_i         = 1'b0;
      host_valid_i     = 1'b0;
      acc_dram_valid_i = 1'b0;
      if (stall)
      begin
         acc_host_ready_i = 1'b0;
         dram_ready_i     = 1'b0;
      end
      else
      begin
         acc_host_ready_i = ($random(seed) & 3) != 0;
         dram_ready_i     = ($random(seed) & 3) != 0;
      end
   endtask

   task automatic write_reg(input logic [2:0] idx, input logic [31:0] data);
      next_cycle();
      csr_we_i    = 1'b1;
      csr_addr_i  = idx;
      csr_wdata_i = data;
      @(negedge clk_i);
   endtask

   // rvalid stays low in the strobe cycle and rises on the edge that samples it
   task automatic read_reg(input logic [2:0] idx, input logic [31:0] expected);
      next_cycle();
      csr_re_i   = 1'b1;
      csr_addr_i = idx;
      @(negedge clk_i);
      compare_value("csr_rvalid_o", 128'(csr_rvalid_o), 128'(1'b0));
      next_cycle();
      @(negedge clk_i);
      compare_value("csr_rvalid_o", 128'(csr_rvalid_o), 128'(1'b1));
      compare_value($sformatf("csr_rdata_o[%0d]", idx), 128'(csr_rdata_o), 128'(expected));
   endtask

   task automatic send_host(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [31:0] out_addr);
      shell_pkg::accel_req_t want;
      want.addr = out_addr;
      want.we   = (strb != 4'h0);
      want.data = data;
      want.strb = strb;
      next_cycle();
      host_req_i.addr = addr[shell_pkg::host_addr_width_lp-1:0];
      host_req_i.we   = want.we;
      host_req_i.data = data;
      host_req_i.strb = strb;
      host_valid_i    = 1'b1;
      @(negedge clk_i);
      while (!host_ready_o)
      begin
         next_cycle();
         host_valid_i = 1'b1;
         @(negedge clk_i);
      end
      host_exp_q.push_back(want);
   endtask

   task automatic send_dram(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [31:0] out_addr);
      shell_pkg::accel_req_t want;
      want.addr = out_addr;
      want.we   = (strb != 4'h0);
      want.data = data;
      want.strb = strb;
      next_cycle();
      acc_dram_req_i      = want;
      acc_dram_req_i.addr = addr;
      acc_dram_valid_i    = 1'b1;
      @(negedge clk_i);
      while (!acc_dram_ready_o)
      begin
         next_cycle();
         acc_dram_valid_i = 1'b1;
         @(negedge clk_i);
      end
      dram_exp_q.push_back(want);
   endtask

   task automatic check_accel_reset(input logic expected);
      next_cycle();
      @(negedge clk_i);
      compare_value("accel_reset_o", 128'(accel_reset_o), 128'(expected));
   endtask

   task automatic stall_cycles(input int n);
      stall = 1'b1;
      repeat (n)
      begin
         next_cycle();
         @(negedge clk_i);
      end
      stall = 1'b0;
   endtask

   task automatic drain_outputs();
      while (host_exp_q.size() != 0 || dram_exp_q.size() != 0)
      begin
         next_cycle();
         @(negedge clk_i);
      end
   endtask

   task automatic close_test();
      if (test_no != 0)
      begin
         drain_outputs();
         test_count++;
         if (error_count == test_err_base)
         begin
            $display("test %0d passed", test_no);
         end
         else
         begin
            $display("test %0d failed with %0d errors", test_no, error_count - test_err_base);
            failed_tests++;
         end
      end
   endtask

   // outputs settle after the rising edge, so both channels are watched on the falling one
   always @(negedge clk_i)
   begin
      if (!reset_i && acc_host_valid_o)
      begin
         if (host_waiting)
            compare_value("acc_host_req_o held", 128'(acc_host_req_o), 128'(host_hold));
         host_waiting = !acc_host_ready_i;
         host_hold    = acc_host_req_o;
         if (acc_host_ready_i)
         begin
            if (host_exp_q.size() == 0)
            begin
               $display("host output sent a request that was never issued");
               error_count++;
            end
            else
            begin
               host_pop = host_exp_q.pop_front();
               compare_value("acc_host_req_o", 128'(acc_host_req_o), 128'(host_pop));
            end
         end
      end
   end

   always @(negedge clk_i)
   begin
      if (!reset_i && dram_valid_o)
      begin
         if (dram_waiting)
            compare_value("dram_req_o held", 128'(dram_req_o), 128'(dram_hold));
         dram_waiting = !dram_ready_i;
         dram_hold    = dram_req_o;
         if (dram_ready_i)
         begin
            if (dram_exp_q.size() == 0)
            begin
               $display("DRAM output sent a request that was never issued");
               error_count++;
            end
            else
            begin
               dram_pop = dram_exp_q.pop_front();
               compare_value("dram_req_o", 128'(dram_req_o), 128'(dram_pop));
            end
         end
      end
   end

   always @(posedge clk_i)
   begin
      cycle_count++;
      if (cycle_count > cycle_limit)
      begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Test failures found");
         $finish;
      end
   end

   initial
   begin
      seed             = 32'hbef79807;
      cycle_count      = 0;
      stim_cycles      = 0;
      error_count      = 0;
      check_count      = 0;
      test_count       = 0;
      failed_tests     = 0;
      test_no          = 0;
      test_err_base    = 0;
      stall            = 1'b0;
      host_waiting     = 1'b0;
      dram_waiting     = 1'b0;
      reset_i          = 1'b1;
      csr_we_i         = 1'b0;
      csr_re_i         = 1'b0;
      csr_addr_i       = '0;
      csr_wdata_i      = '0;
      host_valid_i     = 1'b0;
      host_req_i       = '0;
      acc_host_ready_i = 1'b1;
      acc_dram_valid_i = 1'b0;
      acc_dram_req_i   = '0;
      dram_ready_i     = 1'b1;
      load_stimulus();
      cycle_limit = 10 * stim_cycles + 16;
      repeat (16) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      for (int i = 0; i < op_q.size(); i++)
      begin
         case (op_q[i])
            "T":
            begin
               close_test();
               test_no       = int'(f1_q[i]);
               test_err_base = error_count;
            end
            "A": check_accel_reset(f1_q[i][0]);
            "W": write_reg(f1_q[i][2:0], f2_q[i]);
            "R": read_reg(f1_q[i][2:0], f4_q[i]);
            "H": send_host(f1_q[i], f2_q[i], f3_q[i][3:0], f4_q[i]);
            "D": send_dram(f1_q[i], f2_q[i], f3_q[i][3:0], f4_q[i]);
            "S": stall_cycles(int'(f1_q[i]));
            default:
            begin
               $display("unknown opcode %c in the stimulus file", op_q[i]);
               error_count++;
            end
         endcase
      end
      close_test();
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               test_count, failed_tests, check_count, error_count);
      if (error_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
hdl/shell_pkg.sv
hdl/req_slice.sv
hdl/host_window_map.sv
hdl/dram_rebase.sv
hdl/mem_profiler.sv
hdl/shell_csr.sv
hdl/zynq_accel_shell.sv
verif/tb_zynq_accel_shell.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_zynq_accel_shell
FILELIST := src.f
BIN      := obj_dir/V$(TOP)
PASS_MSG := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir

/* verif/shell_stimulus.txt */
# op f1 f2 f3 f4, fields in hex
# T test, A accel_reset_o, W idx data, R idx - - rdata, H/D addr data strb out_addr, S cycles
T 1 0 0 0
A 1 0 0 0
R 0 0 0 0
R 1 0 0 0
R 2 0 0 0
R 3 0 0 0
R 4 0 0 0
R 7 0 0 0
W 0 1 0 0
A 0 0 0 0
R 0 0 0 1
T 2 0 0 0
H 00001000 a5a5a5a5 f 80001000
H 20000040 12345678 3 00000040
H 0abcdef0 0 0 8abcdef0
T 3 0 0 0
W 2 10000000 0 0
W 1 1 0 0
R 2 0 0 10000000
D 80002000 cafef00d f 10002000
S 6 0 0 0
T 4 0 0 0
D 877ffffc 0 0 177ffffc
R 3 0 0 0
D 87800000 0 0 17800000
R 3 0 0 1
W 0 0 0 0
A 1 0 0 0
W 0 1 0 0
R 3 0 0 0
T 5 0 0 0
D 80000000 1 1 10000000
D 90800000 2 2 20800000
D bf800000 3 4 4f800000
R 4 0 0 1
R 5 0 0 2
R 6 0 0 0
R 7 0 0 80000000
